/* source/axi_lite_pkg.sv */
package axi_lite_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // fixed single-beat encodings
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // shared by AW and AR
    typedef struct packed {
        addr_t       addr;
        logic [7:0]  len;
        logic        valid;
    } axi_ax_t;

    typedef struct packed {
        data_t       data;
        logic [3:0]  strb;
        logic        last;
        logic        valid;
    } axi_w_t;

    typedef struct packed {
        data_t       data;
        logic        last;
        logic        valid;
    } axi_r_t;

    typedef struct packed {
        logic        rden;
        addr_t       riaddr;
        logic        wren;
        addr_t       waddr;
        data_t       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        rvalid;
        addr_t       roaddr;
        data_t       rdata;
    } cpu_rsp_t;

    // address of the following beat in a burst
    function automatic addr_t next_beat_addr(input addr_t a, input logic [1:0] burst);
        if (burst == AXI_BURST_INCR) begin
            return a + (addr_t'(1) << AXI_SIZE_WORD);
        end
        return a;
    endfunction

endpackage

/* source/translate_axi.sv */
`timescale 1ns/1ps

module translate_axi import axi_lite_pkg::*; (
    input  logic     CLK,
    input  logic     RST,
    input  logic     stall,
    output logic     loading,
    input  cpu_req_t req,
    output cpu_rsp_t rsp,
    output axi_ax_t  aw,
    input  logic     awready,
    output axi_w_t   w,
    input  logic     wready,
    output axi_ax_t  ar,
    input  logic     arready,
    input  axi_r_t   r
);

    localparam logic [1:0] RD_IDLE = 2'b00;
    localparam logic [1:0] RD_ADDR = 2'b01;
    localparam logic [1:0] RD_WAIT = 2'b11;

    localparam logic [1:0] WR_IDLE = 2'b00;
    localparam logic [1:0] WR_ADDR = 2'b01;
    localparam logic [1:0] WR_DATA = 2'b11;

    logic [1:0] rd_state;
    logic [1:0] rd_next;
    logic [1:0] wr_state;
    logic [1:0] wr_next;
    logic       r_beat;

    logic       ar_valid_q;
    logic       aw_valid_q;
    logic       w_valid_q;
    addr_t      ar_addr_q;
    addr_t      aw_addr_q;
    data_t      w_data_q;

    assign r_beat = r.valid && r.last;

    // hold the pipeline until the machine returns to idle
    assign loading = (req.rden && rd_next != RD_IDLE) || (req.wren && wr_next != WR_IDLE);

    always_ff @(posedge CLK) begin
        if (RST) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
        end else begin
            rd_state <= rd_next;
            wr_state <= wr_next;
        end
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (req.rden) rd_next = RD_ADDR;
            RD_ADDR: if (arready) rd_next = RD_WAIT;
            RD_WAIT: if (r_beat) rd_next = RD_IDLE;
            default: rd_next = RD_IDLE;
        endcase
    end

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (req.wren) wr_next = WR_ADDR;
            WR_ADDR: if (awready) wr_next = WR_DATA;
            // write completes at the W handshake, no B channel
            WR_DATA: if (wready) wr_next = WR_IDLE;
            default: wr_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            ar_valid_q <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
        end else begin
            ar_valid_q <= (rd_next == RD_ADDR);
            aw_valid_q <= (wr_next == WR_ADDR);
            // W raised with AW, kept until WREADY
            w_valid_q  <= (wr_next != WR_IDLE);
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_state == RD_IDLE && rd_next == RD_ADDR) begin
            ar_addr_q <= req.riaddr;
        end
        if (wr_state == WR_IDLE && wr_next == WR_ADDR) begin
            aw_addr_q <= req.waddr;
            w_data_q  <= req.wdata;
        end
    end

    assign ar = '{addr: ar_addr_q, len: 8'd0, valid: ar_valid_q};
    assign aw = '{addr: aw_addr_q, len: 8'd0, valid: aw_valid_q};
    assign w  = '{data: w_data_q, strb: 4'hf, last: w_valid_q, valid: w_valid_q};

    // cpu result, frozen under stall
    always_ff @(posedge CLK) begin
        if (RST) begin
            rsp.rvalid <= 1'b0;
        end else if (!stall) begin
            if (req.rden && r_beat) begin
                rsp.rvalid <= 1'b1;
                rsp.roaddr <= req.riaddr;
                rsp.rdata  <= r.data;
            end else if (!loading) begin
                rsp.rvalid <= 1'b0;
            end
        end
    end

endmodule

/* source/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram import axi_lite_pkg::*; #(
    parameter int DEPTH_WORDS  = 256,
    parameter int AR_WAIT      = 1,
    parameter int AW_WAIT      = 1,
    parameter int READ_LATENCY = 2
) (
    input  logic    CLK,
    input  logic    RST,
    input  axi_ax_t aw,
    output logic    awready,
    input  axi_w_t  w,
    output logic    wready,
    input  axi_ax_t ar,
    output logic    arready,
    output axi_r_t  r
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int CNT_W = $clog2(AR_WAIT + AW_WAIT + READ_LATENCY + 2);

    data_t            mem [DEPTH_WORDS] = '{default: '0};
    logic [CNT_W-1:0] ar_cnt;
    logic [CNT_W-1:0] aw_cnt;
    logic [CNT_W-1:0] lat_cnt;
    logic [IDX_W-1:0] rd_idx;
    logic             rd_busy;
    logic             aw_held;
    addr_t            wr_addr;
    logic             ar_hs;
    logic             aw_hs;
    logic             w_hs;
    logic             r_fire;

    function automatic logic [IDX_W-1:0] word_index(input addr_t a);
        return IDX_W'((a >> AXI_SIZE_WORD) % DEPTH_WORDS);
    endfunction

    // one read outstanding, one write address held
    assign arready = ar.valid && !rd_busy && ar_cnt == CNT_W'(AR_WAIT);
    assign awready = aw.valid && !aw_held && aw_cnt == CNT_W'(AW_WAIT);
    assign wready  = w.valid && aw_held;

    assign ar_hs = ar.valid && arready;
    assign aw_hs = aw.valid && awready;
    assign w_hs  = w.valid && wready;

    assign r_fire = rd_busy && lat_cnt == CNT_W'(READ_LATENCY);
    assign r      = '{data: mem[rd_idx], last: r_fire, valid: r_fire};

    // wait states, saturating at the programmed count
    always_ff @(posedge CLK) begin
        if (RST || !ar.valid || ar_hs) begin
            ar_cnt <= '0;
        end else if (ar_cnt != CNT_W'(AR_WAIT)) begin
            ar_cnt <= ar_cnt + 1'b1;
        end
        if (RST || !aw.valid || aw_hs) begin
            aw_cnt <= '0;
        end else if (aw_cnt != CNT_W'(AW_WAIT)) begin
            aw_cnt <= aw_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            rd_busy <= 1'b0;
            lat_cnt <= '0;
        end else if (ar_hs) begin
            rd_busy <= 1'b1;
            lat_cnt <= CNT_W'(1);
        end else if (r_fire) begin
            rd_busy <= 1'b0;
        end else if (rd_busy) begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (ar_hs) begin
            rd_idx <= word_index(ar.addr);
        end
    end

    // address held until the last W beat
    always_ff @(posedge CLK) begin
        if (RST) begin
            aw_held <= 1'b0;
        end else if (aw_hs) begin
            aw_held <= 1'b1;
        end else if (w_hs && w.last) begin
            aw_held <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (aw_hs) begin
            wr_addr <= aw.addr;
        end
    end

    always_ff @(posedge CLK) begin
        if (w_hs) begin
            for (int b = 0; b < 4; b++) begin
                if (w.strb[b]) begin
                    mem[word_index(wr_addr)][8*b +: 8] <= w.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* source/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem import axi_lite_pkg::*; #(
    parameter int DEPTH_WORDS  = 256,
    parameter int AR_WAIT      = 1,
    parameter int AW_WAIT      = 1,
    parameter int READ_LATENCY = 2
) (
    input  logic     CLK,
    input  logic     RST,
    input  logic     stall,
    output logic     loading,
    input  cpu_req_t req,
    output cpu_rsp_t rsp
);

    axi_ax_t aw;
    axi_w_t  w;
    axi_ax_t ar;
    axi_r_t  r;
    logic    awready;
    logic    wready;
    logic    arready;

    translate_axi u_translate (
        .CLK     (CLK),
        .RST     (RST),
        .stall   (stall),
        .loading (loading),
        .req     (req),
        .rsp     (rsp),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .ar      (ar),
        .arready (arready),
        .r       (r)
    );

    axi_sram #(
        .DEPTH_WORDS  (DEPTH_WORDS),
        .AR_WAIT      (AR_WAIT),
        .AW_WAIT      (AW_WAIT),
        .READ_LATENCY (READ_LATENCY)
    ) u_sram (
        .CLK     (CLK),
        .RST     (RST),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .ar      (ar),
        .arready (arready),
        .r       (r)
    );

endmodule

/* sim/mem_subsystem_properties.sv */
`timescale 1ns/1ps

module mem_subsystem_properties import axi_lite_pkg::*; (
    input logic     CLK,
    input logic     RST,
    input logic     loading,
    input cpu_req_t req,
    input axi_ax_t  aw,
    input logic     awready,
    input axi_w_t   w,
    input logic     wready,
    input axi_ax_t  ar,
    input logic     arready
);

    // a raised valid keeps its payload until ready
    ar_hold: assert property (@(posedge CLK) disable iff (RST)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr))
        else $error("AR dropped or changed before ARREADY");

    aw_hold: assert property (@(posedge CLK) disable iff (RST)
        aw.valid && !awready |=> aw.valid && $stable(aw.addr))
        else $error("AW dropped or changed before AWREADY");

    w_hold: assert property (@(posedge CLK) disable iff (RST)
        w.valid && !wready |=> w.valid && $stable(w.data))
        else $error("W dropped or changed before WREADY");

    // single full-word beat
    w_shape: assert property (@(posedge CLK) disable iff (RST)
        w.valid |-> w.last && w.strb == 4'hf)
        else $error("W beat without WLAST or with a partial strobe");

    loading_needs_req: assert property (@(posedge CLK) disable iff (RST)
        loading |-> req.rden || req.wren)
        else $error("loading high with no request present");

    reset_quiet: assert property (@(posedge CLK)
        RST |=> !ar.valid && !aw.valid && !w.valid)
        else $error("valid raised during reset");

endmodule

bind translate_axi mem_subsystem_properties u_props (
    .CLK     (CLK),
    .RST     (RST),
    .loading (loading),
    .req     (req),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .ar      (ar),
    .arready (arready)
);

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem import axi_lite_pkg::*; ();

    localparam int DEPTH          = 64;
    localparam int AR_WAIT        = 2;
    localparam int AW_WAIT        = 1;
    localparam int READ_LATENCY   = 3;
    // R arrives this many edges after the edge that first sees rden
    localparam int RD_FIRST       = AR_WAIT + READ_LATENCY + 1;
    localparam int NUM_OPS        = 400;
    localparam int CYCLES_PER_OP  = 20;
    localparam int RESET_CYCLES   = 5;
    // random ops plus the final read-back of up to every word
    localparam int TIMEOUT_CYCLES = (NUM_OPS + DEPTH) * CYCLES_PER_OP + RESET_CYCLES;

    logic     CLK = 1'b0;
    logic     RST;
    logic     stall;
    logic     loading;
    cpu_req_t req;
    cpu_rsp_t rsp;

    data_t    model [DEPTH];
    logic     written [DEPTH];
    cpu_rsp_t exp_rsp;
    logic     rsp_known;
    cpu_req_t last_req;
    logic     last_stall;
    logic     last_loading;
    logic     retired;
    int       stall_run;
    int       op_edge;
    int       cycle_cnt = 0;

    mem_subsystem #(
        .DEPTH_WORDS  (DEPTH),
        .AR_WAIT      (AR_WAIT),
        .AW_WAIT      (AW_WAIT),
        .READ_LATENCY (READ_LATENCY)
    ) dut0 (
        .CLK     (CLK),
        .RST     (RST),
        .stall   (stall),
        .loading (loading),
        .req     (req),
        .rsp     (rsp)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_run("timeout: a request never finished");
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic int word_of(input addr_t a);
        return int'(a[31:2]) % DEPTH;
    endfunction

    // the read machine restarts one edge after each beat while rden is held
    function automatic logic read_beat_at(input int e);
        return (e >= RD_FIRST) && ((e - RD_FIRST) % (RD_FIRST + 1) == 0);
    endfunction

    task automatic check_rsp(input cpu_rsp_t actual, input cpu_rsp_t expected);
        logic bad;
        // address and data mean nothing before the first read result
        bad = rsp_known ? (actual !== expected) : (actual.rvalid !== expected.rvalid);
        if (bad) begin
            stop_run($sformatf("FAIL at %0t: rsp %b/%h/%h, expected %b/%h/%h", $time,
                actual.rvalid, actual.roaddr, actual.rdata,
                expected.rvalid, expected.roaddr, expected.rdata));
        end
    endtask

    task automatic check_loading(input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_run($sformatf("FAIL at %0t: loading %b, expected %b", $time,
                actual, expected));
        end
    endtask

    // never high for more than three cycles in a row
    task automatic drive_stall();
        if (stall_run >= 3 || $urandom % 4 != 0) begin
            stall = 1'b0;
            stall_run = 0;
        end else begin
            stall = 1'b1;
            stall_run++;
        end
    endtask

    // what the rising edge just passed should have done to rsp and the model
    task automatic judge_edge();
        int ri;
        int wi;
        ri = word_of(last_req.riaddr);
        wi = word_of(last_req.waddr);
        retired = !last_stall && !last_loading;
        if (retired) begin
            if (last_req.rden) begin
                exp_rsp = '{rvalid: 1'b1, roaddr: last_req.riaddr, rdata: model[ri]};
                rsp_known = 1'b1;
            end else begin
                exp_rsp.rvalid = 1'b0;
            end
            if (last_req.wren) begin
                model[wi] = last_req.wdata;
                written[wi] = 1'b1;
            end
        end else if (!last_stall && last_req.rden && last_req.wren
                     && read_beat_at(op_edge)) begin
            // read beat taken while the write still holds loading
            exp_rsp = '{rvalid: 1'b1, roaddr: last_req.riaddr, rdata: model[ri]};
            rsp_known = 1'b1;
        end
        op_edge++;
        check_rsp(rsp, exp_rsp);
    endtask

    task automatic tick(input logic fresh);
        #1;
        if (!req.rden && !req.wren) begin
            check_loading(loading, 1'b0);
        end else if (fresh) begin
            check_loading(loading, 1'b1);
        end
        last_req     = req;
        last_stall   = stall;
        last_loading = loading;
        @(negedge CLK);
        judge_edge();
    endtask

    // the CPU holds its request until an edge with loading and stall both low
    task automatic issue(input cpu_req_t op);
        logic fresh;
        req = op;
        fresh = 1'b1;
        op_edge = 0;
        do begin
            drive_stall();
            tick(fresh);
            fresh = 1'b0;
        end while (!retired);
    endtask

    task automatic idle_cycle();
        req = '0;
        drive_stall();
        tick(1'b0);
    endtask

    task automatic random_op();
        cpu_req_t op;
        int kind;
        int ri;
        int wi;
        kind = int'($urandom % 8);
        ri = int'($urandom % DEPTH);
        wi = int'($urandom % DEPTH);
        if (wi == ri) begin
            wi = (wi + 1) % DEPTH;
        end
        op = '0;
        op.rden = (kind < 4) || (kind == 7);
        op.wren = (kind >= 4);
        op.riaddr = addr_t'(ri) << 2;
        op.waddr = addr_t'(wi) << 2;
        op.wdata = $urandom;
        issue(op);
    endtask

    initial begin
        cpu_req_t back;
        void'($urandom(32'haa6f_832b));
        RST = 1'b1;
        stall = 1'b0;
        req = '0;
        exp_rsp = '0;
        rsp_known = 1'b0;
        stall_run = 0;
        op_edge = 0;
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
            written[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        check_loading(loading, 1'b0);
        check_rsp(rsp, exp_rsp);

        for (int n = 0; n < NUM_OPS; n++) begin
            if ($urandom % 4 == 0) begin
                idle_cycle();
            end
            random_op();
        end

        // memory contents against the model
        for (int i = 0; i < DEPTH; i++) begin
            if (written[i]) begin
                back = '0;
                back.rden = 1'b1;
                back.riaddr = addr_t'(i) << 2;
                issue(back);
            end
        end
        idle_cycle();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* compile.f */
source/axi_lite_pkg.sv
source/translate_axi.sv
source/axi_sram.sv
source/mem_subsystem.sv
sim/mem_subsystem_properties.sv
sim/tb_mem_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
